/* pyramid_cfg.svh */
`ifndef PYRAMID_CFG_SVH
`define PYRAMID_CFG_SVH

// input image geometry
`define PYR_WIDTH 8
`define PYR_HEIGHT 8

// greyscale pixel width
`define PYR_BIT_DEPTH 8

// uart bit period in clk_100mhz cycles
`define PYR_CLKS_PER_BAUD 50

// cycles the send button must hold a level before it is accepted
`define PYR_DEBOUNCE_CYCLES 16

`endif

/* pyramid_pkg.sv */
`include "pyramid_cfg.svh"

package pyramid_pkg;

    // one greyscale sample
    typedef logic [`PYR_BIT_DEPTH-1:0] pixel_t;

    // address into the full resolution frame buffer
    typedef logic [$clog2(`PYR_WIDTH*`PYR_HEIGHT)-1:0] full_addr_t;

    // address into the half resolution level buffer
    typedef logic [$clog2(`PYR_WIDTH*`PYR_HEIGHT/4)-1:0] half_addr_t;

endpackage

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_cfg.svh"

module uart_rx import pyramid_pkg::*; (
    input  logic   clk_100mhz,
    input  logic   sys_rst,
    input  logic   rx_i,
    output pixel_t data_o,
    output logic   valid_o
);
    localparam int CLKS  = `PYR_CLKS_PER_BAUD;
    localparam int CNT_W = $clog2(CLKS);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic             rx_meta;
    logic             rx_sync;
    logic [1:0]       state;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    pixel_t           shift_q;

    assign data_o = shift_q;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            rx_meta <= 1'b1;                                   // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state    <= S_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_sync) begin
                        state <= S_START;                      // falling edge of start bit
                    end
                end
                S_START: begin
                    if (baud_cnt == CNT_W'(CLKS/2 - 1)) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? S_IDLE : S_DATA; // glitch check at mid bit
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (baud_cnt == CNT_W'(CLKS - 1)) begin
                        baud_cnt <= '0;
                        shift_q  <= {rx_sync, shift_q[`PYR_BIT_DEPTH-1:1]}; // lsb first
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= S_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (baud_cnt == CNT_W'(CLKS - 1)) begin
                        baud_cnt <= '0;
                        valid_o  <= rx_sync;                   // drop frames with a bad stop bit
                        state    <= S_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_cfg.svh"

module uart_tx import pyramid_pkg::*; (
    input  logic   clk_100mhz,
    input  logic   sys_rst,
    input  pixel_t data_i,
    input  logic   start_i,
    output logic   tx_o,
    output logic   busy_o
);
    localparam int CLKS     = `PYR_CLKS_PER_BAUD;
    localparam int CNT_W    = $clog2(CLKS);
    localparam int LAST_BIT = `PYR_BIT_DEPTH + 1;              // index of the stop bit
    localparam int BIT_W    = $clog2(LAST_BIT + 1);

    logic [CNT_W-1:0]        baud_cnt;
    logic [BIT_W-1:0]        bit_cnt;
    logic [`PYR_BIT_DEPTH:0] frame_q;                          // data bits then stop bit
    logic                    baud_tick;

    assign baud_tick = busy_o && (baud_cnt == CNT_W'(CLKS - 1));

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            busy_o   <= 1'b0;
            tx_o     <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy_o) begin
            if (start_i) begin
                busy_o   <= 1'b1;
                tx_o     <= 1'b0;                              // start bit
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_tick) begin
            baud_cnt <= '0;
            if (bit_cnt == BIT_W'(LAST_BIT)) begin
                busy_o <= 1'b0;                                // stop bit has been on the line
            end else begin
                tx_o    <= frame_q[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (!busy_o && start_i) begin
            frame_q <= {1'b1, data_i};
        end else if (baud_tick) begin
            frame_q <= {1'b1, frame_q[`PYR_BIT_DEPTH:1]};
        end
    end

    // the sender upstream must wait out each frame before the next strobe
    assert property (@(posedge clk_100mhz) disable iff (sys_rst) start_i |-> !busy_o)
        else $error("uart_tx start while busy");

endmodule

`default_nettype wire

/* pixel_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_ram import pyramid_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  logic                     clk_100mhz,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  pixel_t                   wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output pixel_t                   rdata_o
);
    pixel_t mem [DEPTH];

    always_ff @(posedge clk_100mhz) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read data lands one cycle after the address
    always_ff @(posedge clk_100mhz) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire

/* image_loader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_cfg.svh"

module image_loader import pyramid_pkg::*; (
    input  logic       clk_100mhz,
    input  logic       sys_rst,
    input  pixel_t     rx_data_i,
    input  logic       rx_valid_i,
    output logic       we_o,
    output full_addr_t waddr_o,
    output pixel_t     wdata_o,
    output logic       start_o,
    output logic       loaded_o
);
    localparam int LAST_ADDR = `PYR_WIDTH * `PYR_HEIGHT - 1;

    full_addr_t addr_q;

    assign we_o    = rx_valid_i && !loaded_o;                  // frozen once the frame is in
    assign waddr_o = addr_q;
    assign wdata_o = rx_data_i;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            addr_q   <= '0;
            start_o  <= 1'b0;
            loaded_o <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (we_o) begin
                addr_q <= addr_q + 1'b1;
                if (addr_q == full_addr_t'(LAST_ADDR)) begin
                    loaded_o <= 1'b1;
                    start_o  <= 1'b1;                          // kick the downsampler once
                end
            end
        end
    end

    // one strobe per received byte, so each pixel advances the address once
    assert property (@(posedge clk_100mhz) disable iff (sys_rst)
                     rx_valid_i |=> !rx_valid_i)
        else $error("rx strobe held for more than one cycle");

endmodule

`default_nettype wire

/* pyramid_downsampler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_cfg.svh"

module pyramid_downsampler import pyramid_pkg::*; (
    input  logic       clk_100mhz,
    input  logic       sys_rst,
    input  logic       start_i,
    input  pixel_t     rdata_i,
    output full_addr_t raddr_o,
    output logic       we_o,
    output half_addr_t waddr_o,
    output pixel_t     wdata_o,
    output logic       done_o
);
    localparam int ACC_W     = `PYR_BIT_DEPTH + 2;             // room for four pixels
    localparam int COL_BITS  = $clog2(`PYR_WIDTH / 2);
    localparam int ROW_BITS  = $clog2(`PYR_HEIGHT / 2);
    localparam int LAST_PIX  = `PYR_WIDTH * `PYR_HEIGHT / 4 - 1;

    logic             active;
    logic [2:0]       phase;                                   // 0..3 reads, 4 write
    half_addr_t       idx;
    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] sum;

    // source pixel for this phase, dy from phase[1] and dx from phase[0]
    assign raddr_o = {idx[COL_BITS +: ROW_BITS], phase[1], idx[COL_BITS-1:0], phase[0]};

    assign sum     = acc + ACC_W'(rdata_i);
    assign we_o    = active && (phase == 3'd4);
    assign waddr_o = idx;
    assign wdata_o = sum[ACC_W-1:2];                           // truncated mean

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            active <= 1'b0;
            phase  <= '0;
            idx    <= '0;
            done_o <= 1'b0;
        end else if (!active) begin
            if (start_i) begin
                active <= 1'b1;                                // first read went out this cycle
                phase  <= 3'd1;
            end
        end else if (phase == 3'd4) begin
            phase <= '0;
            idx   <= idx + 1'b1;
            if (idx == half_addr_t'(LAST_PIX)) begin
                active <= 1'b0;
                done_o <= 1'b1;
            end
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (phase == 3'd1) begin
            acc <= ACC_W'(rdata_i);                            // top-left pixel
        end else begin
            acc <= sum;
        end
    end

endmodule

`default_nettype wire

/* level_sender.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_cfg.svh"

module level_sender import pyramid_pkg::*; (
    input  logic       clk_100mhz,
    input  logic       sys_rst,
    input  logic       press_i,
    input  logic       ready_i,
    input  pixel_t     rdata_i,
    input  logic       tx_busy_i,
    output half_addr_t raddr_o,
    output pixel_t     tx_data_o,
    output logic       tx_start_o,
    output logic       sending_o
);
    localparam int LAST_ADDR = `PYR_WIDTH * `PYR_HEIGHT / 4 - 1;

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_FETCH = 3'd1;
    localparam logic [2:0] S_WAIT  = 3'd2;
    localparam logic [2:0] S_START = 3'd3;
    localparam logic [2:0] S_DRAIN = 3'd4;

    logic [2:0] state;
    half_addr_t addr_q;

    assign raddr_o   = addr_q;
    assign sending_o = (state != S_IDLE);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state      <= S_IDLE;
            addr_q     <= '0;
            tx_start_o <= 1'b0;
        end else begin
            tx_start_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (press_i && ready_i) begin
                        addr_q <= '0;
                        state  <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_WAIT;                      // ram read in flight
                S_WAIT: begin
                    if (!tx_busy_i) begin
                        tx_start_o <= 1'b1;
                        state      <= S_START;
                    end
                end
                S_START: begin
                    if (addr_q == half_addr_t'(LAST_ADDR)) begin
                        state <= S_DRAIN;
                    end else begin
                        addr_q <= addr_q + 1'b1;
                        state  <= S_FETCH;
                    end
                end
                S_DRAIN: begin
                    if (!tx_busy_i) begin
                        state <= S_IDLE;                       // last stop bit is out
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (state == S_WAIT && !tx_busy_i) begin
            tx_data_o <= rdata_i;
        end
    end

endmodule

`default_nettype wire

/* button_debouncer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_cfg.svh"

module button_debouncer (
    input  logic clk_100mhz,
    input  logic sys_rst,
    input  logic btn_i,
    output logic press_o
);
    localparam int N     = `PYR_DEBOUNCE_CYCLES;
    localparam int CNT_W = $clog2(N);

    logic             btn_meta;
    logic             btn_sync;
    logic             clean_q;
    logic             clean_d;
    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            clean_q  <= 1'b0;
            clean_d  <= 1'b0;
            cnt_q    <= '0;
            press_o  <= 1'b0;
        end else begin
            btn_meta <= btn_i;
            btn_sync <= btn_meta;
            clean_d  <= clean_q;
            press_o  <= clean_q && !clean_d;                   // rising edge only
            if (btn_sync == clean_q) begin
                cnt_q <= '0;                                   // bounce restarts the wait
            end else if (cnt_q == CNT_W'(N - 1)) begin
                clean_q <= btn_sync;
                cnt_q   <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* pyramid_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pyramid_cfg.svh"

module pyramid_top import pyramid_pkg::*; (
    input  logic clk_100mhz,
    input  logic sys_rst,
    input  logic uart_rx_i,
    input  logic send_btn_i,
    output logic uart_tx_o,
    output logic image_loaded_o,
    output logic pyramid_done_o,
    output logic sending_o
);
    localparam int FRAME_DEPTH = `PYR_WIDTH * `PYR_HEIGHT;
    localparam int LEVEL_DEPTH = FRAME_DEPTH / 4;

    pixel_t     rx_byte;
    logic       rx_valid;
    logic       frame_we;
    full_addr_t frame_waddr;
    pixel_t     frame_wdata;
    full_addr_t frame_raddr;
    pixel_t     frame_rdata;
    logic       start;
    logic       level_we;
    half_addr_t level_waddr;
    pixel_t     level_wdata;
    half_addr_t level_raddr;
    pixel_t     level_rdata;
    logic       press;
    pixel_t     tx_data;
    logic       tx_start;
    logic       tx_busy;

    uart_rx u_uart_rx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .rx_i       (uart_rx_i),
        .data_o     (rx_byte),
        .valid_o    (rx_valid)
    );

    image_loader u_image_loader (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .rx_data_i  (rx_byte),
        .rx_valid_i (rx_valid),
        .we_o       (frame_we),
        .waddr_o    (frame_waddr),
        .wdata_o    (frame_wdata),
        .start_o    (start),
        .loaded_o   (image_loaded_o)
    );

    pixel_ram #(.DEPTH(FRAME_DEPTH)) frame_ram (
        .clk_100mhz (clk_100mhz),
        .we_i       (frame_we),
        .waddr_i    (frame_waddr),
        .wdata_i    (frame_wdata),
        .raddr_i    (frame_raddr),
        .rdata_o    (frame_rdata)
    );

    pyramid_downsampler u_downsampler (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .start_i    (start),
        .rdata_i    (frame_rdata),
        .raddr_o    (frame_raddr),
        .we_o       (level_we),
        .waddr_o    (level_waddr),
        .wdata_o    (level_wdata),
        .done_o     (pyramid_done_o)
    );

    pixel_ram #(.DEPTH(LEVEL_DEPTH)) level_ram (
        .clk_100mhz (clk_100mhz),
        .we_i       (level_we),
        .waddr_i    (level_waddr),
        .wdata_i    (level_wdata),
        .raddr_i    (level_raddr),
        .rdata_o    (level_rdata)
    );

    button_debouncer u_debouncer (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .btn_i      (send_btn_i),
        .press_o    (press)
    );

    level_sender u_level_sender (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .press_i    (press),
        .ready_i    (pyramid_done_o),
        .rdata_i    (level_rdata),
        .tx_busy_i  (tx_busy),
        .raddr_o    (level_raddr),
        .tx_data_o  (tx_data),
        .tx_start_o (tx_start),
        .sending_o  (sending_o)
    );

    uart_tx u_uart_tx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .data_i     (tx_data),
        .start_i    (tx_start),
        .tx_o       (uart_tx_o),
        .busy_o     (tx_busy)
    );

endmodule

`default_nettype wire

/* tb_pyramid_top.sv */
`timescale 1ns/1ps
`include "pyramid_cfg.svh"

module tb_pyramid_top;
    localparam int CLKS         = `PYR_CLKS_PER_BAUD;
    localparam int NUM_PIX      = `PYR_WIDTH * `PYR_HEIGHT;
    localparam int NUM_LVL      = NUM_PIX / 4;
    localparam int BYTE_CLKS    = 10 * CLKS;                  // one 8N1 frame
    localparam int NUM_EXTRA    = NUM_PIX;                    // enough to rerun an unfrozen load
    // rx bytes, three level transfers and two idle windows of 40 bit times
    localparam int RUN_BYTES    = NUM_PIX + NUM_EXTRA + 3 * NUM_LVL + 8;
    localparam int MARGIN_BYTES = 60;
    localparam longint WATCHDOG_NS = longint'(RUN_BYTES + MARGIN_BYTES) * BYTE_CLKS * 10;

    logic        clk_100mhz;
    logic        sys_rst;
    logic        uart_rx_i;
    logic        send_btn_i;
    logic        uart_tx_o;
    logic        image_loaded_o;
    logic        pyramid_done_o;
    logic        sending_o;

    logic [7:0]  test_mem [0:NUM_PIX+NUM_LVL-1];              // image then expected level
    int unsigned lcg_state;
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          errors_at_start;

    pyramid_top u_pyramid_top (
        .clk_100mhz     (clk_100mhz),
        .sys_rst        (sys_rst),
        .uart_rx_i      (uart_rx_i),
        .send_btn_i     (send_btn_i),
        .uart_tx_o      (uart_tx_o),
        .image_loaded_o (image_loaded_o),
        .pyramid_done_o (pyramid_done_o),
        .sending_o      (sending_o)
    );

    always #5 clk_100mhz = ~clk_100mhz;

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic begin_test();
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic end_test(input string name);
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAILED with %0d errors", test_count, name,
                     error_count - errors_at_start);
        end
    endtask

    task automatic uart_send(input logic [7:0] value);
        logic [9:0] frame;
        int         gap;
        frame = {1'b1, value, 1'b0};                          // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_100mhz);
            #1;
            uart_rx_i = frame[i];
            repeat (CLKS - 1) @(posedge clk_100mhz);
        end
        gap = next_random() % 16;                             // idle line between frames
        repeat (gap) @(posedge clk_100mhz);
    endtask

    task automatic press_button();
        @(posedge clk_100mhz);
        #1;
        send_btn_i = 1'b1;
        repeat (`PYR_DEBOUNCE_CYCLES + 8) @(posedge clk_100mhz);
        #1;
        send_btn_i = 1'b0;
        repeat (`PYR_DEBOUNCE_CYCLES + 8) @(posedge clk_100mhz);
    endtask

    task automatic wait_start_bit(input int max_cycles, output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < max_cycles) begin
            @(negedge clk_100mhz);
            if (uart_tx_o === 1'b0) begin
                seen = 1'b1;
            end
            n++;
        end
    endtask

    task automatic uart_receive(input int max_cycles, output logic [7:0] value, output bit ok);
        bit seen;
        value = '0;
        wait_start_bit(max_cycles, seen);
        ok = seen;
        if (seen) begin
            repeat (CLKS / 2) @(negedge clk_100mhz);          // centre of start bit
            if (uart_tx_o !== 1'b0) begin
                report_failure("start bit on uart_tx_o ended before its centre");
                ok = 1'b0;
            end
            check_value(sending_o, 1'b1, "sending_o low while a byte is on uart_tx_o");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS) @(negedge clk_100mhz);
                value[i] = uart_tx_o;
            end
            repeat (CLKS) @(negedge clk_100mhz);
            if (uart_tx_o !== 1'b1) begin
                report_failure("stop bit on uart_tx_o was not high");
                ok = 1'b0;
            end
        end
    endtask

    task automatic receive_level(input string label);
        logic [7:0] value;
        bit         ok;
        int         idx;
        int         n;
        ok  = 1'b1;
        idx = 0;
        while (ok && idx < NUM_LVL) begin
            uart_receive(2 * BYTE_CLKS, value, ok);
            if (!ok) begin
                report_failure($sformatf("%s: byte %0d of the level never arrived", label, idx));
            end else begin
                check_value(value, test_mem[NUM_PIX + idx],
                            $sformatf("%s: level byte %0d", label, idx));
            end
            idx++;
        end
        n = 0;
        while (sending_o === 1'b1 && n < 4 * BYTE_CLKS) begin
            @(negedge clk_100mhz);
            n++;
        end
        if (sending_o !== 1'b0) begin
            report_failure($sformatf("%s: sending_o stayed high after the last byte", label));
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: run did not finish within %0d ns, stopped by the watchdog", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin : main_seq
        bit seen;
        int sum;
        int n;
        clk_100mhz   = 1'b0;
        sys_rst      = 1'b1;
        uart_rx_i    = 1'b1;                                  // uart line idles high
        send_btn_i   = 1'b0;
        lcg_state    = 17;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        $readmemh("pyramid_testdata.hex", test_mem);
        repeat (2) @(posedge clk_100mhz);
        #1;
        sys_rst = 1'b0;

        // expected level in the file must be the 2x2 truncated mean of the image
        begin_test();
        if ($isunknown(test_mem[NUM_PIX + NUM_LVL - 1])) begin
            report_failure("pyramid_testdata.hex did not fill the whole table");
        end
        for (int r = 0; r < `PYR_HEIGHT / 2; r++) begin
            for (int c = 0; c < `PYR_WIDTH / 2; c++) begin
                sum = test_mem[2*r*`PYR_WIDTH + 2*c]     + test_mem[2*r*`PYR_WIDTH + 2*c + 1]
                    + test_mem[(2*r+1)*`PYR_WIDTH + 2*c] + test_mem[(2*r+1)*`PYR_WIDTH + 2*c + 1];
                check_value(sum >> 2, test_mem[NUM_PIX + r*`PYR_WIDTH/2 + c],
                            $sformatf("testdata level entry row %0d col %0d", r, c));
            end
        end
        end_test("testdata consistency");

        begin_test();
        @(negedge clk_100mhz);
        check_value(uart_tx_o, 1'b1, "uart_tx_o not idle high after reset");
        check_value(image_loaded_o, 1'b0, "image_loaded_o high after reset");
        check_value(pyramid_done_o, 1'b0, "pyramid_done_o high after reset");
        check_value(sending_o, 1'b0, "sending_o high after reset");
        end_test("reset state");

        begin_test();
        fork
            press_button();
            wait_start_bit(40 * CLKS, seen);
        join
        check_value(seen, 1'b0, "start bit on uart_tx_o before any image");
        end_test("press before image");

        begin_test();
        for (int i = 0; i < NUM_PIX; i++) begin
            uart_send(test_mem[i]);
        end
        @(negedge clk_100mhz);
        check_value(image_loaded_o, 1'b1, "image_loaded_o after 64 pixels");
        n = 0;
        while (pyramid_done_o !== 1'b1 && n < 200) begin
            @(negedge clk_100mhz);
            n++;
        end
        check_value(pyramid_done_o, 1'b1, "pyramid_done_o within 200 cycles");
        end_test("image load and pyramid");

        begin_test();
        fork
            press_button();
            receive_level("first transfer");
        join
        end_test("level transfer");

        begin_test();
        for (int i = 0; i < NUM_EXTRA; i++) begin
            uart_send(8'(next_random()));                     // must not reach the frozen frame
        end
        @(negedge clk_100mhz);
        check_value(image_loaded_o, 1'b1, "image_loaded_o after extra bytes");
        fork
            press_button();
            receive_level("second transfer");
        join
        end_test("repeat transfer after extra bytes");

        begin_test();
        fork
            begin
                press_button();
                repeat (3 * BYTE_CLKS) @(posedge clk_100mhz);
                @(negedge clk_100mhz);
                check_value(sending_o, 1'b1, "transfer not running at the second press");
                press_button();
            end
            receive_level("transfer with extra press");
        join
        wait_start_bit(40 * CLKS, seen);
        check_value(seen, 1'b0, "byte after the sixteenth");
        end_test("press during transfer");

        $display("%0d tests run, %0d failed, %0d errors in total",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* pyramid_testdata.hex */
// first 64 tokens: input image, one row of 8 pixels per line, row-major
// last 16 tokens: expected 4x4 level, truncated 2x2 mean, one level row per line
// input image
00 04 10 13 20 21 FF FE
08 0C 11 12 23 22 FD FC
40 41 80 80 01 02 33 44
42 43 81 7F 03 05 55 66
10 20 30 40 50 60 70 80
90 A0 B0 C0 D0 E0 F0 FF
00 00 FF FF 07 08 AA 55
00 01 FF FE 09 0A 55 AA
// expected level
06 11 21 FD
41 80 02 4C
58 78 98 B7
00 FE 08 7F

/* sim.f */
+incdir+.
pyramid_pkg.sv
uart_rx.sv
uart_tx.sv
pixel_ram.sv
image_loader.sv
pyramid_downsampler.sv
level_sender.sv
button_debouncer.sv
pyramid_top.sv
tb_pyramid_top.sv

/* Bender.yml */
package:
  name: pyramid

sources:
  - include_dirs:
      - .
    files:
      - pyramid_pkg.sv
      - uart_rx.sv
      - uart_tx.sv
      - pixel_ram.sv
      - image_loader.sv
      - pyramid_downsampler.sv
      - level_sender.sv
      - button_debouncer.sv
      - pyramid_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pyramid_top.sv
